/* common/flash_pkg.sv */
package flash_pkg;

	// ----------------------------------------
	// sizes and defaults
	localparam int ADDR_BYTES_DEF = 3;	// 24-bit flash address
	localparam int CLK_DIV_DEF    = 2;	// clk cycles per sck half period
	localparam int LEN_W          = 9;	// counts 1..256 bytes
	localparam int MAX_ADDR_W     = 32;	// address port, low bytes sent

	// ----------------------------------------
	// single line command set
	typedef enum logic [7:0] {
		OP_PROGRAM = 8'h02,	// page program
		OP_READ    = 8'h03,	// normal read, no dummy clocks
		OP_RDSR    = 8'h05,	// read status register 1
		OP_WREN    = 8'h06	// set write enable latch
	} opcode_e;

	// ----------------------------------------
	// status register 1, raw byte or named bits
	typedef union packed {
		logic [7:0] raw;	// as shifted in on miso
		struct packed {
			logic [5:0] rsvd;	// protect bits, not used
			logic       wel;	// write enable latch
			logic       wip;	// write in progress
		} bits;
	} flash_status_u;

endpackage

/* common/spi_byte_if.sv */
interface spi_byte_if;

	// sequencer side
	logic       start;	// one cycle pulse per byte
	logic [7:0] tx_byte;	// sampled with start
	logic       last;	// final byte of frame, sampled with start

	// shifter side
	logic       done;	// one pulse per byte
	logic [7:0] rx_byte;	// valid at done, held until next start

	modport master (
		output start, tx_byte, last,
		input  done, rx_byte
	);

	modport slave (
		input  start, tx_byte, last,
		output done, rx_byte
	);

endinterface

/* verilog/spi_byte_shifter.sv */
module spi_byte_shifter #(
	parameter int CLK_DIV = flash_pkg::CLK_DIV_DEF	// clk cycles per sck half period
) (
	input  logic       clk,
	input  logic       rst,
	spi_byte_if.slave  byte_if,
	output logic       spi_cs_n_o,
	output logic       spi_sck_o,
	output logic       spi_mosi_o,
	input  logic       spi_miso_i
);

	localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

	logic             busy;	// 8 sck periods running
	logic             gap;	// cs high after a last byte
	logic [DIV_W-1:0] div_cnt;
	logic [2:0]       bit_cnt;
	logic             sck, cs_n;
	logic [7:0]       shreg;	// tx out at msb, rx in at lsb
	logic             miso_q;	// bit caught on rising edge
	logic             last_q;
	logic             tick, final_fall;

	assign tick       = (busy || gap) && div_cnt == DIV_W'(CLK_DIV - 1);	// half period end
	assign final_fall = busy && tick && sck && bit_cnt == 3'd7;

	assign byte_if.done    = (final_fall && !last_q) || (gap && tick);
	assign byte_if.rx_byte = {shreg[6:0], miso_q};	// last bit never shifted in
	assign spi_cs_n_o      = cs_n;
	assign spi_sck_o       = sck;
	assign spi_mosi_o      = shreg[7];

	// ----------------------------------------
	// divider, bit count, sck and cs
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy    <= 1'b0;
			gap     <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
			sck     <= 1'b0;	// mode 0 idles low
			cs_n    <= 1'b1;
		end else if (byte_if.start) begin
			busy    <= 1'b1;
			div_cnt <= '0;
			bit_cnt <= '0;
			cs_n    <= 1'b0;	// falls the cycle after start
		end else if (busy) begin
			if (tick) begin
				div_cnt <= '0;
				sck     <= ~sck;
				if (sck) begin	// falling edge
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7) begin
						busy <= 1'b0;
						gap  <= last_q;
						cs_n <= last_q;	// deselect ends the frame
					end
				end
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end else if (gap) begin
			if (tick) begin
				gap     <= 1'b0;
				div_cnt <= '0;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	// ----------------------------------------
	// data path
	always_ff @(posedge clk) begin
		if (byte_if.start) begin
			shreg  <= byte_if.tx_byte;
			last_q <= byte_if.last;
		end else if (busy && tick) begin
			if (!sck)
				miso_q <= spi_miso_i;	// sample on rise
			else if (bit_cnt != 3'd7)
				shreg <= {shreg[6:0], miso_q};	// next mosi bit on fall
		end
	end

	// sequencer waits for done before the next byte
	assert property (@(posedge clk) disable iff (rst)
		byte_if.start |-> !busy && !gap);

endmodule

/* sequencer/flash_sequencer.sv */
module flash_sequencer #(
	parameter int ADDR_BYTES = flash_pkg::ADDR_BYTES_DEF
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            cmd_valid_i,
	output logic                            cmd_ready_o,
	input  logic                            cmd_write_i,
	input  logic [flash_pkg::MAX_ADDR_W-1:0] cmd_addr_i,
	input  logic [flash_pkg::LEN_W-1:0]      cmd_len_i,
	input  logic                            wr_valid_i,
	output logic                            wr_ready_o,
	input  logic [7:0]                      wr_data_i,
	output logic                            rd_valid_o,
	input  logic                            rd_ready_i,
	output logic [7:0]                      rd_data_o,
	output logic                            done_o,
	spi_byte_if.master                      byte_if
);
	import flash_pkg::*;

	localparam int AW   = ADDR_BYTES * 8;	// address bits on the wire
	localparam int AC_W = $clog2(ADDR_BYTES + 1);

	localparam logic [1:0] S_IDLE  = 2'd0;	// ready for a command
	localparam logic [1:0] S_XFER  = 2'd1;	// byte in the shifter
	localparam logic [1:0] S_WAIT  = 2'd2;	// stalled on wr data or rd ack

	localparam logic [1:0] FR_WREN = 2'd0;
	localparam logic [1:0] FR_PROG = 2'd1;
	localparam logic [1:0] FR_RDSR = 2'd2;
	localparam logic [1:0] FR_READ = 2'd3;

	localparam logic [1:0] PH_OPC  = 2'd0;
	localparam logic [1:0] PH_ADDR = 2'd1;
	localparam logic [1:0] PH_DATA = 2'd2;

	logic [1:0]       state, frame, phase;
	logic [AC_W-1:0]  addr_cnt;	// address bytes still to send
	logic [LEN_W-1:0] len_cnt;	// data bytes still to move
	logic [AW-1:0]    addr_q;	// top byte goes out next
	logic [7:0]       tx_q;
	logic             start_q, last_q;
	logic             cmd_hs, step, issue, rx_load, rd_room;
	flash_status_u    status;
	// decision for the byte after the one just finished
	logic             nxt_go, nxt_fin, nxt_wr, nxt_cnt, nxt_last;
	logic [1:0]       nxt_frame, nxt_phase;
	logic [7:0]       nxt_tx;

	assign cmd_ready_o     = (state == S_IDLE);
	assign cmd_hs          = cmd_valid_i && cmd_ready_o;
	assign step            = (state == S_XFER && byte_if.done) || state == S_WAIT;
	assign issue           = step && nxt_go && !nxt_fin;
	assign rx_load         = state == S_XFER && byte_if.done && frame == FR_READ
	                         && phase == PH_DATA;
	assign rd_room         = !rx_load && (!rd_valid_o || rd_ready_i);	// buffer empty or leaving
	assign status          = flash_status_u'(byte_if.rx_byte);
	assign wr_ready_o      = step && nxt_wr;
	assign byte_if.start   = start_q;
	assign byte_if.tx_byte = tx_q;
	assign byte_if.last    = last_q;

	// ----------------------------------------
	// next byte selection
	always_comb begin
		nxt_go    = 1'b1;
		nxt_fin   = 1'b0;
		nxt_wr    = 1'b0;
		nxt_cnt   = 1'b0;
		nxt_last  = 1'b0;
		nxt_tx    = 8'h00;	// dummy byte clocks miso in
		nxt_frame = frame;
		nxt_phase = PH_DATA;
		if (frame == FR_WREN) begin	// latch set, program follows
			nxt_frame = FR_PROG;
			nxt_phase = PH_OPC;
			nxt_tx    = OP_PROGRAM;
		end else if (frame == FR_RDSR && phase == PH_OPC) begin
			nxt_last = 1'b1;	// status byte ends the frame
		end else if (frame == FR_RDSR) begin
			if (status.bits.wip) begin	// still busy, poll again
				nxt_phase = PH_OPC;
				nxt_tx    = OP_RDSR;
			end else begin
				nxt_fin = 1'b1;
			end
		end else if (phase == PH_OPC || (phase == PH_ADDR && addr_cnt != '0)) begin
			nxt_phase = PH_ADDR;
			nxt_tx    = addr_q[AW-1 -: 8];	// high byte first
		end else if (last_q) begin	// data frame complete
			if (frame == FR_PROG) begin
				nxt_frame = FR_RDSR;
				nxt_phase = PH_OPC;
				nxt_tx    = OP_RDSR;
			end else begin
				nxt_fin = 1'b1;
				nxt_go  = rd_room;	// finish once final byte handed off
			end
		end else begin
			nxt_cnt  = 1'b1;
			nxt_last = (len_cnt == LEN_W'(1));
			if (frame == FR_PROG) begin
				nxt_wr = 1'b1;
				nxt_tx = wr_data_i;
				nxt_go = wr_valid_i;
			end else begin
				nxt_go = rd_room;
			end
		end
	end

	// ----------------------------------------
	// control state
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state      <= S_IDLE;
			frame      <= FR_READ;
			phase      <= PH_OPC;
			addr_cnt   <= '0;
			len_cnt    <= '0;
			start_q    <= 1'b0;
			last_q     <= 1'b0;
			done_o     <= 1'b0;
			rd_valid_o <= 1'b0;
		end else begin
			start_q <= 1'b0;
			done_o  <= 1'b0;
			if (cmd_hs) begin
				state    <= S_XFER;
				start_q  <= 1'b1;
				last_q   <= cmd_write_i;	// wren is a one byte frame
				frame    <= cmd_write_i ? FR_WREN : FR_READ;
				phase    <= PH_OPC;
				addr_cnt <= AC_W'(ADDR_BYTES);
				len_cnt  <= cmd_len_i;
			end else if (step) begin
				if (!nxt_go) begin
					state <= S_WAIT;	// sck parked low, cs held
				end else if (nxt_fin) begin
					state  <= S_IDLE;
					done_o <= 1'b1;
				end else begin
					state   <= S_XFER;
					start_q <= 1'b1;
					last_q  <= nxt_last;
					frame   <= nxt_frame;
					phase   <= nxt_phase;
					if (nxt_phase == PH_ADDR)
						addr_cnt <= addr_cnt - 1'b1;
					if (nxt_cnt)
						len_cnt <= len_cnt - 1'b1;
				end
			end
			if (rx_load)
				rd_valid_o <= 1'b1;
			else if (rd_ready_i)
				rd_valid_o <= 1'b0;
		end
	end

	// ----------------------------------------
	// payload, no reset
	always_ff @(posedge clk) begin
		if (cmd_hs) begin
			tx_q   <= cmd_write_i ? OP_WREN : OP_READ;
			addr_q <= cmd_addr_i[AW-1:0];	// upper port bits unused
		end else if (issue) begin
			tx_q <= nxt_tx;
			if (nxt_phase == PH_ADDR)
				addr_q <= addr_q << 8;
		end
		if (rx_load)
			rd_data_o <= byte_if.rx_byte;
	end

	// read byte held until taken
	assert property (@(posedge clk) disable iff (rst)
		rd_valid_o && !rd_ready_i |=> rd_valid_o && $stable(rd_data_o));

	// one command at a time, busy until its done pulse
	assert property (@(posedge clk) disable iff (rst)
		cmd_hs |=> !cmd_ready_o until done_o);

endmodule

/* verilog/spi_flash_top.sv */
module spi_flash_top #(
	parameter int ADDR_BYTES = flash_pkg::ADDR_BYTES_DEF,	// address bytes per frame
	parameter int CLK_DIV    = flash_pkg::CLK_DIV_DEF	// clk cycles per sck half
) (
	input  logic                            clk,
	input  logic                            rst,
	// command channel
	input  logic                            cmd_valid_i,
	output logic                            cmd_ready_o,
	input  logic                            cmd_write_i,	// 1 program, 0 read
	input  logic [flash_pkg::MAX_ADDR_W-1:0] cmd_addr_i,
	input  logic [flash_pkg::LEN_W-1:0]      cmd_len_i,	// 1..256
	// program data in
	input  logic                            wr_valid_i,
	output logic                            wr_ready_o,
	input  logic [7:0]                      wr_data_i,
	// read data out
	output logic                            rd_valid_o,
	input  logic                            rd_ready_i,
	output logic [7:0]                      rd_data_o,
	output logic                            done_o,	// command finished
	// flash pins
	output logic                            spi_cs_n_o,
	output logic                            spi_sck_o,
	output logic                            spi_mosi_o,
	input  logic                            spi_miso_i
);

	spi_byte_if byte_bus ();	// sequencer <-> shifter

	flash_sequencer #(.ADDR_BYTES(ADDR_BYTES)) u_seq (
		.clk(clk), .rst(rst),
		.cmd_valid_i(cmd_valid_i), .cmd_ready_o(cmd_ready_o),
		.cmd_write_i(cmd_write_i), .cmd_addr_i(cmd_addr_i), .cmd_len_i(cmd_len_i),
		.wr_valid_i(wr_valid_i), .wr_ready_o(wr_ready_o), .wr_data_i(wr_data_i),
		.rd_valid_o(rd_valid_o), .rd_ready_i(rd_ready_i), .rd_data_o(rd_data_o),
		.done_o(done_o),
		.byte_if(byte_bus.master)
	);

	spi_byte_shifter #(.CLK_DIV(CLK_DIV)) u_shift (
		.clk(clk), .rst(rst),
		.byte_if(byte_bus.slave),
		.spi_cs_n_o(spi_cs_n_o), .spi_sck_o(spi_sck_o),
		.spi_mosi_o(spi_mosi_o), .spi_miso_i(spi_miso_i)
	);

endmodule

/* tests/flash_model.sv */
module flash_model #(
	parameter int ADDR_BYTES = flash_pkg::ADDR_BYTES_DEF,	// address bytes per frame
	parameter int MEM_BYTES  = 1024	// modeled window of the array
) (
	input  logic spi_cs_n_i,
	input  logic spi_sck_i,
	input  logic spi_mosi_i,
	output logic spi_miso_o,
	input  logic done_i,	// controller command finished
	output int   err_cnt_o
);
	import flash_pkg::*;

	logic [7:0]    mem [MEM_BYTES];	// flash array
	logic [7:0]    in_sr, out_sr;	// mosi in, miso out
	logic [7:0]    op;	// opcode of the open frame
	logic          wel, pend;	// pend while a program is not yet reported done
	int            bit_n, byte_n;	// position inside the frame
	int            addr, busy_left;	// busy_left counts status reads with wip set
	flash_status_u st;

	initial begin
		foreach (mem[i])
			mem[i] = 8'($urandom);	// erased parts never look all ff
		op         = 8'h00;
		wel        = 1'b0;
		pend       = 1'b0;
		busy_left  = 0;
		err_cnt_o  = 0;
		spi_miso_o = 1'b0;
	end

	always @(negedge spi_cs_n_i) begin
		bit_n  = 0;
		byte_n = 0;
	end

	// ----------------------------------------
	// mode 0, capture on rising sck
	always @(posedge spi_sck_i) begin
		if (!spi_cs_n_i) begin
			in_sr = {in_sr[6:0], spi_mosi_i};
			bit_n++;
			if (bit_n == 8) begin
				bit_n = 0;
				if (byte_n == 0) begin
					op   = in_sr;
					addr = 0;
					if (op == OP_RDSR) begin
						st          = '0;
						st.bits.wel = wel;
						st.bits.wip = busy_left != 0;
						if (busy_left != 0)
							busy_left--;
						else
							pend = 1'b0;	// write reported complete
						out_sr = st.raw;
					end
				end else if (byte_n <= ADDR_BYTES) begin
					addr = (addr << 8) | in_sr;	// high byte first
				end else if (op == OP_PROGRAM && wel) begin
					mem[addr % MEM_BYTES] = in_sr;
					addr = (addr & ~255) | ((addr + 1) & 255);	// wraps inside the page
				end
				if (op == OP_READ && byte_n >= ADDR_BYTES) begin
					out_sr = mem[addr % MEM_BYTES];	// next byte for the read stream
					addr++;
				end
				byte_n++;
			end
		end
	end

	// next miso bit on falling sck
	always @(negedge spi_sck_i) begin
		if (!spi_cs_n_i) begin
			spi_miso_o = out_sr[7];
			out_sr     = out_sr << 1;
		end
	end

	// ----------------------------------------
	// frame end, latch and busy timer
	always @(posedge spi_cs_n_i) begin
		if (op == OP_WREN && byte_n == 1) begin
			wel = 1'b1;
		end else if (op == OP_PROGRAM && wel && byte_n > ADDR_BYTES) begin
			wel       = 1'b0;
			pend      = 1'b1;
			busy_left = $urandom_range(5, 1);
		end
		op = 8'h00;
	end

	always @(posedge done_i) begin
		assert (!pend)
		else begin
			err_cnt_o++;
			$display("flash model: done_o came before a status read showed the write complete");
		end
	end

endmodule

/* tests/tb_spi_flash.sv */
module tb_spi_flash;
	import flash_pkg::*;

	localparam int N_CMD     = 40;
	localparam int MEM_BYTES = 1024;	// four pages
	// two frames per write incl read back, 24 bytes at 40 cycles, 5 polls at 120
	localparam int LIMIT_CYC = N_CMD * 2 * 24 * 40 + N_CMD * 5 * 120;

	logic                  clk, rst;
	logic                  cmd_valid, cmd_ready, cmd_write;
	logic [MAX_ADDR_W-1:0] cmd_addr;
	logic [LEN_W-1:0]      cmd_len;
	logic                  wr_valid, wr_ready, rd_valid, rd_ready, done;
	logic [7:0]            wr_data, rd_data, rd_prev;
	logic                  cs_n, sck, mosi, miso, rd_held;
	logic [7:0]            ref_mem [MEM_BYTES];	// expected flash contents
	logic [7:0]            wr_q[$], exp_q[$];	// bytes still to send, bytes still due
	int                    errors, model_errors, cmd_cnt, done_cnt;

	spi_flash_top #(.ADDR_BYTES(3), .CLK_DIV(2)) uut (
		.clk(clk), .rst(rst),
		.cmd_valid_i(cmd_valid), .cmd_ready_o(cmd_ready), .cmd_write_i(cmd_write),
		.cmd_addr_i(cmd_addr), .cmd_len_i(cmd_len),
		.wr_valid_i(wr_valid), .wr_ready_o(wr_ready), .wr_data_i(wr_data),
		.rd_valid_o(rd_valid), .rd_ready_i(rd_ready), .rd_data_o(rd_data),
		.done_o(done),
		.spi_cs_n_o(cs_n), .spi_sck_o(sck), .spi_mosi_o(mosi), .spi_miso_i(miso)
	);

	flash_model #(.ADDR_BYTES(3), .MEM_BYTES(MEM_BYTES)) flash (
		.spi_cs_n_i(cs_n), .spi_sck_i(sck), .spi_mosi_i(mosi), .spi_miso_o(miso),
		.done_i(done), .err_cnt_o(model_errors)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
		if (done)
			done_cnt++;

	// ----------------------------------------
	// program data source, valid held until taken
	always @(posedge clk) begin : wr_feed
		if (wr_valid && wr_ready)
			wr_q.delete(0);
		if (!wr_valid || wr_ready) begin
			wr_valid <= wr_q.size() != 0 && $urandom_range(2, 0) != 0;
			wr_data  <= wr_q.size() != 0 ? wr_q[0] : 8'h00;
		end
	end

	// read data sink with random back pressure
	always @(posedge clk) begin : rd_sink
		if (rd_held) begin
			assert (rd_valid && rd_data == rd_prev)
			else begin
				errors++;
				$display("ERR rd_valid_o %h rd_data_o %h while stalled, held %h",
					rd_valid, rd_data, rd_prev);
			end
		end
		if (rd_valid && rd_ready) begin
			assert (exp_q.size() != 0)
			else begin
				errors++;
				$display("a read byte arrived with no byte expected");
			end
			if (exp_q.size() != 0) begin
				assert (rd_data == exp_q[0])
				else begin
					errors++;
					$display("ERR rd_data_o got %h expected %h", rd_data, exp_q[0]);
				end
				exp_q.delete(0);
			end
		end
		rd_held  = rd_valid && !rd_ready;
		rd_prev  = rd_data;
		rd_ready <= 1'($urandom_range(1, 0));
	end

	// ----------------------------------------
	// one command, handshake to done pulse
	task automatic run_cmd(input logic wr, input int addr, input int len);
		cmd_valid <= 1'b1;
		cmd_write <= wr;
		cmd_addr  <= addr;
		cmd_len   <= len;
		do
			@(posedge clk);
		while (!cmd_ready);
		cmd_valid <= 1'b0;
		cmd_cnt++;
		for (int i = 0; i < len; i++) begin
			if (wr) begin
				ref_mem[addr + i] = 8'($urandom);	// reference updated at issue
				wr_q.push_back(ref_mem[addr + i]);
			end else begin
				exp_q.push_back(ref_mem[addr + i]);
			end
		end
		do begin
			@(posedge clk);
			assert (done || !cmd_ready)
			else begin
				errors++;
				$display("cmd_ready_o went high before done_o for command at %h", addr);
			end
		end while (!done);
		assert (wr_q.size() == 0 && exp_q.size() == 0)
		else begin
			errors++;
			$display("command at %h ended with %0d write and %0d read bytes left over",
				addr, wr_q.size(), exp_q.size());
		end
	endtask

	initial begin : main
		int page, len, off;
		void'($urandom(48951));
		errors    = 0;
		cmd_cnt   = 0;
		done_cnt  = 0;
		rd_held   = 1'b0;
		rst       = 1'b1;
		cmd_valid = 1'b0;
		cmd_write = 1'b0;
		cmd_addr  = '0;
		cmd_len   = '0;
		wr_valid  = 1'b0;
		wr_data   = 8'h00;
		rd_ready  = 1'b0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		assert (cs_n && cmd_ready && !rd_valid && !wr_ready && !done)
		else begin
			errors++;
			$display("ERR idle spi_cs_n_o=%h cmd_ready_o=%h rd_valid_o=%h wr_ready_o=%h done_o=%h",
				cs_n, cmd_ready, rd_valid, wr_ready, done);
		end
		assert (!sck)
		else begin
			errors++;
			$display("ERR spi_sck_o idle got %h expected 0", sck);
		end
		foreach (ref_mem[i])
			ref_mem[i] = flash.mem[i];	// model array starts random
		repeat (N_CMD) begin
			page = $urandom_range(MEM_BYTES / 256 - 1, 0);
			len  = $urandom_range(16, 1);
			off  = $urandom_range(256 - len, 0);	// stays inside one page
			if ($urandom_range(1, 0) != 0) begin
				run_cmd(1'b1, page * 256 + off, len);
				run_cmd(1'b0, page * 256 + off, len);	// read back the programmed range
			end else begin
				run_cmd(1'b0, page * 256 + off, len);
			end
		end
		repeat (4) @(posedge clk);
		assert (done_cnt == cmd_cnt)
		else begin
			errors++;
			$display("ERR done_o pulses %h for %h commands", done_cnt, cmd_cnt);
		end
		$display("errors: %0d testbench, %0d flash model", errors, model_errors);
		if (errors == 0 && model_errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	initial begin : watchdog
		#(LIMIT_CYC * 4);
		$display("timeout: the run did not finish within %0d clock cycles", LIMIT_CYC);
		$display("errors: %0d testbench, %0d flash model", errors, model_errors);
		$display("Some tests failed");
		$finish;
	end

endmodule

/* files.f */
common/flash_pkg.sv
common/spi_byte_if.sv
verilog/spi_byte_shifter.sv
sequencer/flash_sequencer.sv
verilog/spi_flash_top.sv
tests/flash_model.sv
tests/tb_spi_flash.sv

/* Bender.yml */
package:
  name: spi_flash_ctrl

sources:
  - common/flash_pkg.sv
  - common/spi_byte_if.sv
  - verilog/spi_byte_shifter.sv
  - sequencer/flash_sequencer.sv
  - verilog/spi_flash_top.sv
  - target: test
    files:
      - tests/flash_model.sv
      - tests/tb_spi_flash.sv
